// File: lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// data and address width
`define LC3B_WORD_W 16

// register index width, also the BR nzp field
`define LC3B_REG_W 3

// testbench memory depth in words
`define TB_MEM_WORDS 256

`endif

// File: lc3b_mem_pipe.sv
`timescale 1ns/100ps

module lc3b_mem_pipe
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ex_mem_t    in_item,
    output logic       ready,
    input  logic       resp,
    input  lc3b_word   rdata,
    output logic       read,
    output logic       write,
    output logic [1:0] wmask,
    output lc3b_word   address,
    output lc3b_word   wdata,
    output mem_wb_t    wb_item,
    output logic       flush,
    output lc3b_word   br_target
);

    ex_mem_t ex_stage_item;
    mem_wb_t mem_stage_item;
    logic    stall;

    assign ready = !stall;

    // holds the item while memory is busy
    pipe_reg #(
        .payload_t (ex_mem_t)
    ) ex_mem_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (stall),
        .bubble (!in_item.valid),
        .d      (in_item),
        .q      (ex_stage_item)
    );

    mem_access mem_access_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .item    (ex_stage_item),
        .resp    (resp),
        .rdata   (rdata),
        .read    (read),
        .write   (write),
        .wmask   (wmask),
        .address (address),
        .wdata   (wdata),
        .stall   (stall)
    );

    mem_result mem_result_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .item      (ex_stage_item),
        .address   (address),
        .rdata     (rdata),
        .resp      (resp),
        .stall     (stall),
        .out_item  (mem_stage_item),
        .flush     (flush),
        .br_target (br_target)
    );

    // bubble into write-back during a stall
    pipe_reg #(
        .payload_t (mem_wb_t)
    ) mem_wb_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .bubble (stall),
        .d      (mem_stage_item),
        .q      (wb_item)
    );

endmodule

// File: lc3b_types.sv
`include "lc3b_macros.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // address source
    typedef enum logic [2:0] {
        marmux_alu      = 3'd0,
        marmux_pc       = 3'd1,
        marmux_br_add   = 3'd2,
        marmux_trap     = 3'd4,
        marmux_indirect = 3'd5
    } marmux_sel_t;

    // store data source
    typedef enum logic [2:0] {
        mdrmux_sr1_high = 3'd2,
        mdrmux_sr2      = 3'd3,
        mdrmux_sr2_byte = 3'd4
    } mdrmux_sel_t;

    // write-back source
    typedef enum logic [2:0] {
        rfmux_alu       = 3'd0,
        rfmux_mem       = 3'd1,
        rfmux_br_add    = 3'd2,
        rfmux_pc        = 3'd3,
        rfmux_zext_low  = 3'd4,
        rfmux_zext_byte = 3'd6
    } regfilemux_sel_t;

    typedef struct packed {
        lc3b_opcode      opcode;
        logic            load_cc;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic [1:0]      mem_byte_enable;
        marmux_sel_t     marmux_sel;
        mdrmux_sel_t     mdrmux_sel;
        regfilemux_sel_t regfilemux_sel;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word ctrl;
        lc3b_word         alu_out;
        lc3b_word         pc_out;
        lc3b_word         br_add_out;
        lc3b_word         sr1_out;
        lc3b_word         sr2_out;
        lc3b_word         instruction;
        lc3b_reg          dest;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     load_regfile;
        lc3b_reg  dest;
        lc3b_word regfile_data;
        logic     br_en;
        logic     jmp_jsr_en;
        logic     b11;
        logic     trap_en;
        lc3b_word trap_mem;
    } mem_wb_t;

endpackage

// File: mem_access.sv
`timescale 1ns/100ps

module mem_access
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ex_mem_t    item,
    input  logic       resp,
    input  lc3b_word   rdata,
    output logic       read,
    output logic       write,
    output logic [1:0] wmask,
    output lc3b_word   address,
    output lc3b_word   wdata,
    output logic       stall
);

    logic        ind_op;
    logic        ind_q;
    lc3b_word    ind_ptr;
    lc3b_word    trap_vec;
    marmux_sel_t mar_sel;

    assign ind_op   = item.valid && (item.ctrl.opcode == op_ldi || item.ctrl.opcode == op_sti);
    assign trap_vec = lc3b_word'({item.instruction[7:0], 1'b0});

    // first indirect step reads the pointer, second step uses it
    always_comb begin
        mar_sel = item.ctrl.marmux_sel;
        if (ind_op) begin
            mar_sel = ind_q ? marmux_indirect : marmux_alu;
        end
    end

    always_comb begin
        case (mar_sel)
            marmux_pc:       address = item.pc_out;
            marmux_br_add:   address = item.br_add_out;
            marmux_trap:     address = trap_vec;
            marmux_indirect: address = ind_ptr;
            default:         address = item.alu_out;
        endcase
    end

    always_comb begin
        if (ind_op && !ind_q) begin
            read  = 1'b1;
            write = 1'b0;
        end else if (ind_op) begin
            read  = (item.ctrl.opcode == op_ldi);
            write = (item.ctrl.opcode == op_sti);
        end else begin
            read  = item.valid && item.ctrl.mem_read;
            write = item.valid && item.ctrl.mem_write;
        end
    end

    always_comb begin
        case (item.ctrl.mdrmux_sel)
            mdrmux_sr1_high: wdata = item.sr1_out << 8;
            mdrmux_sr2_byte: wdata = address[0] ? item.sr2_out << 8 : item.sr2_out;
            default:         wdata = item.sr2_out;
        endcase
    end

    always_comb begin
        if (item.ctrl.opcode == op_stb) begin
            wmask = address[0] ? 2'b10 : 2'b01;
        end else begin
            wmask = item.ctrl.mem_byte_enable;
        end
    end

    assign stall = ((read || write) && !resp) || (ind_op && !ind_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ind_q <= 1'b0;
        end else if (resp) begin
            ind_q <= ind_op && !ind_q;
        end
    end

    // pointer word from the first access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ind_ptr <= '0;
        end else if (resp && ind_op && !ind_q) begin
            ind_ptr <= rdata;
        end
    end

endmodule

// File: mem_result.sv
`timescale 1ns/100ps

module mem_result
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  ex_mem_t  item,
    input  lc3b_word address,
    input  lc3b_word rdata,
    input  logic     resp,
    input  logic     stall,
    output mem_wb_t  out_item,
    output logic     flush,
    output lc3b_word br_target
);

    logic [7:0] ld_byte;
    lc3b_word   regfile_data;
    lc3b_nzp    cc_d;
    lc3b_nzp    cc_q;
    logic       br_taken;
    logic       trap_en;

    // odd address selects the high byte
    assign ld_byte = address[0] ? rdata[15:8] : rdata[7:0];

    always_comb begin
        case (item.ctrl.regfilemux_sel)
            rfmux_mem:       regfile_data = rdata;
            rfmux_br_add:    regfile_data = item.br_add_out;
            rfmux_pc:        regfile_data = item.pc_out;
            rfmux_zext_low:  regfile_data = {8'h00, rdata[7:0]};
            rfmux_zext_byte: regfile_data = {8'h00, ld_byte};
            default:         regfile_data = item.alu_out;
        endcase
    end

    always_comb begin
        cc_d[2] = regfile_data[15];
        cc_d[1] = (regfile_data == '0);
        cc_d[0] = !regfile_data[15] && (regfile_data != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_q <= '0;
        end else if (item.valid && item.ctrl.load_cc && !stall) begin
            cc_q <= cc_d;
        end
    end

    // dest carries the nzp field for BR
    assign br_taken  = item.valid && (item.ctrl.opcode == op_br) && |(item.dest & cc_q);
    assign flush     = br_taken;
    assign br_target = br_taken ? item.br_add_out : '0;

    assign trap_en = item.valid && (item.ctrl.opcode == op_trap) && resp;

    always_comb begin
        out_item.valid        = item.valid && !stall;
        out_item.load_regfile = item.ctrl.load_regfile;
        out_item.dest         = item.dest;
        out_item.regfile_data = regfile_data;
        out_item.br_en        = br_taken;
        out_item.jmp_jsr_en   = item.valid &&
                                (item.ctrl.opcode == op_jmp || item.ctrl.opcode == op_jsr);
        out_item.b11          = item.instruction[11];
        out_item.trap_en      = trap_en;
        out_item.trap_mem     = trap_en ? rdata : '0;
    end

endmodule

// File: pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // hold wins over bubble so a stalled item is never lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (hold) begin
            q <= q;
        end else if (bubble) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_lc3b_mem_pipe -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    exit 1
fi
exit 0

// File: tb_lc3b_mem_pipe.sv
`timescale 1ns/100ps
`include "lc3b_macros.svh"

module tb_lc3b_mem_pipe
    import lc3b_types::*;
();

    typedef struct packed {
        ex_mem_t  item;
        logic     exp_ld_rf;
        lc3b_reg  exp_dest;
        lc3b_word exp_data;
        logic     exp_br;
        logic     exp_jmp;
        logic     exp_b11;
        logic     exp_trap;
        lc3b_word exp_trap_mem;
        logic     exp_flush;
        lc3b_word exp_target;
        logic     chk_mem;
        lc3b_word chk_addr;
        lc3b_word chk_word;
    } row_t;

    localparam int NUM_ROWS = 13;
    localparam int CYCLE_LIMIT = NUM_ROWS * 10 + 20;

    logic       clk;
    logic       rst_n;
    ex_mem_t    in_item;
    logic       ready;
    logic       resp;
    lc3b_word   rdata;
    logic       read;
    logic       write;
    logic [1:0] wmask;
    lc3b_word   address;
    lc3b_word   wdata;
    mem_wb_t    wb_item;
    logic       flush;
    lc3b_word   br_target;

    row_t rows [NUM_ROWS];
    int   cycles;

    lc3b_mem_pipe lc3b_mem_pipe_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_item   (in_item),
        .ready     (ready),
        .resp      (resp),
        .rdata     (rdata),
        .read      (read),
        .write     (write),
        .wmask     (wmask),
        .address   (address),
        .wdata     (wdata),
        .wb_item   (wb_item),
        .flush     (flush),
        .br_target (br_target)
    );

    tb_mem_model mem_model (
        .clk     (clk),
        .rst_n   (rst_n),
        .read    (read),
        .write   (write),
        .wmask   (wmask),
        .address (address),
        .wdata   (wdata),
        .resp    (resp),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: pipeline stopped producing results after %0d cycles", cycles);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // initial memory contents, word index in high byte
    function automatic lc3b_word fill_word(input lc3b_word byte_addr);
        logic [7:0] i;
        i = byte_addr[8:1];
        return {i, ~i};
    endfunction

    function automatic ex_mem_t make_item(input lc3b_opcode op, input marmux_sel_t mar,
                                          input mdrmux_sel_t mdr, input regfilemux_sel_t rf,
                                          input logic rd, input logic wr, input logic ld_rf,
                                          input logic ld_cc, input lc3b_word alu,
                                          input lc3b_word pc, input lc3b_word br_add,
                                          input lc3b_word sr2, input lc3b_word instr,
                                          input lc3b_reg dest);
        ex_mem_t it;
        it = '0;
        it.valid                = 1'b1;
        it.ctrl.opcode          = op;
        it.ctrl.load_cc         = ld_cc;
        it.ctrl.load_regfile    = ld_rf;
        it.ctrl.mem_read        = rd;
        it.ctrl.mem_write       = wr;
        it.ctrl.mem_byte_enable = 2'b11;
        it.ctrl.marmux_sel      = mar;
        it.ctrl.mdrmux_sel      = mdr;
        it.ctrl.regfilemux_sel  = rf;
        it.alu_out              = alu;
        it.pc_out               = pc;
        it.br_add_out           = br_add;
        it.sr2_out              = sr2;
        it.instruction          = instr;
        it.dest                 = dest;
        return it;
    endfunction

    // expected results default to a plain ALU pass-through
    function automatic row_t base_row(input ex_mem_t it);
        row_t r;
        r = '0;
        r.item       = it;
        r.exp_ld_rf  = it.ctrl.load_regfile;
        r.exp_dest   = it.dest;
        r.exp_data   = it.alu_out;
        r.exp_b11    = it.instruction[11];
        return r;
    endfunction

    task automatic check_value(input string name, input lc3b_word got, input lc3b_word exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_table();
        // word store and load
        rows[0] = base_row(make_item(op_str, marmux_alu, mdrmux_sr2, rfmux_alu, 0, 1, 0, 0,
                                     16'h0040, 16'h0100, 16'h0, 16'h1234, 16'h7000, 3'd1));
        rows[0].chk_mem  = 1'b1;
        rows[0].chk_addr = 16'h0040;
        rows[0].chk_word = 16'h1234;
        rows[1] = base_row(make_item(op_ldr, marmux_alu, mdrmux_sr2, rfmux_mem, 1, 0, 1, 0,
                                     16'h0040, 16'h0102, 16'h0, 16'h0, 16'h6600, 3'd3));
        rows[1].exp_data = 16'h1234;
        // byte store to odd address, then byte loads
        rows[2] = base_row(make_item(op_stb, marmux_alu, mdrmux_sr2_byte, rfmux_alu, 0, 1, 0, 0,
                                     16'h0041, 16'h0104, 16'h0, 16'h00ab, 16'h3000, 3'd2));
        rows[2].chk_mem  = 1'b1;
        rows[2].chk_addr = 16'h0040;
        rows[2].chk_word = 16'hab34;
        rows[3] = base_row(make_item(op_ldb, marmux_alu, mdrmux_sr2, rfmux_zext_byte, 1, 0, 1, 0,
                                     16'h0040, 16'h0106, 16'h0, 16'h0, 16'h2a00, 3'd4));
        rows[3].exp_data = 16'h0034;
        rows[4] = base_row(make_item(op_ldb, marmux_alu, mdrmux_sr2, rfmux_zext_byte, 1, 0, 1, 0,
                                     16'h0041, 16'h0108, 16'h0, 16'h0, 16'h2c00, 3'd5));
        rows[4].exp_data = 16'h00ab;
        // pointer at x60 points to x80
        rows[5] = base_row(make_item(op_str, marmux_alu, mdrmux_sr2, rfmux_alu, 0, 1, 0, 0,
                                     16'h0060, 16'h010a, 16'h0, 16'h0080, 16'h7000, 3'd0));
        rows[5].chk_mem  = 1'b1;
        rows[5].chk_addr = 16'h0060;
        rows[5].chk_word = 16'h0080;
        rows[6] = base_row(make_item(op_ldi, marmux_alu, mdrmux_sr2, rfmux_mem, 1, 0, 1, 0,
                                     16'h0060, 16'h010c, 16'h0, 16'h0, 16'ha600, 3'd6));
        rows[6].exp_data = fill_word(16'h0080);
        rows[7] = base_row(make_item(op_sti, marmux_alu, mdrmux_sr2, rfmux_alu, 0, 1, 0, 0,
                                     16'h0060, 16'h010e, 16'h0, 16'hbeef, 16'hb000, 3'd7));
        rows[7].chk_mem  = 1'b1;
        rows[7].chk_addr = 16'h0080;
        rows[7].chk_word = 16'hbeef;
        // negative result sets n
        rows[8] = base_row(make_item(op_add, marmux_alu, mdrmux_sr2, rfmux_alu, 0, 0, 1, 1,
                                     16'h8001, 16'h0110, 16'h0, 16'h0, 16'h1000, 3'd1));
        rows[9] = base_row(make_item(op_br, marmux_br_add, mdrmux_sr2, rfmux_alu, 0, 0, 0, 0,
                                     16'h0, 16'h0112, 16'h0222, 16'h0, 16'h0800, 3'b100));
        rows[9].exp_br     = 1'b1;
        rows[9].exp_flush  = 1'b1;
        rows[9].exp_target = 16'h0222;
        rows[10] = base_row(make_item(op_br, marmux_br_add, mdrmux_sr2, rfmux_alu, 0, 0, 0, 0,
                                      16'h0, 16'h0114, 16'h0333, 16'h0, 16'h0600, 3'b011));
        rows[11] = base_row(make_item(op_jmp, marmux_alu, mdrmux_sr2, rfmux_alu, 0, 0, 0, 0,
                                      16'h0400, 16'h0116, 16'h0, 16'h0, 16'hc1c0, 3'd0));
        rows[11].exp_jmp = 1'b1;
        // vector x25 reads word at x4a
        rows[12] = base_row(make_item(op_trap, marmux_trap, mdrmux_sr2, rfmux_pc, 1, 0, 1, 0,
                                      16'h0, 16'h0300, 16'h0, 16'h0, 16'hf025, 3'd7));
        rows[12].exp_data     = 16'h0300;
        rows[12].exp_trap     = 1'b1;
        rows[12].exp_trap_mem = fill_word(16'h004a);
    endtask

    task automatic run_row(input row_t r);
        logic     flush_seen;
        lc3b_word target_seen;
        flush_seen  = 1'b0;
        target_seen = '0;
        @(posedge clk);
        in_item <= r.item;
        do begin
            @(negedge clk);
        end while (!ready);
        @(posedge clk);
        in_item <= '0;
        forever begin
            @(negedge clk);
            if (flush) begin
                flush_seen  = 1'b1;
                target_seen = br_target;
            end
            if (wb_item.valid) break;
        end
        check_value("wb_item.load_regfile", 16'(wb_item.load_regfile), 16'(r.exp_ld_rf));
        check_value("wb_item.dest", 16'(wb_item.dest), 16'(r.exp_dest));
        check_value("wb_item.regfile_data", wb_item.regfile_data, r.exp_data);
        check_value("wb_item.br_en", 16'(wb_item.br_en), 16'(r.exp_br));
        check_value("wb_item.jmp_jsr_en", 16'(wb_item.jmp_jsr_en), 16'(r.exp_jmp));
        check_value("wb_item.b11", 16'(wb_item.b11), 16'(r.exp_b11));
        check_value("wb_item.trap_en", 16'(wb_item.trap_en), 16'(r.exp_trap));
        check_value("wb_item.trap_mem", wb_item.trap_mem, r.exp_trap_mem);
        check_value("flush", 16'(flush_seen), 16'(r.exp_flush));
        if (r.exp_flush) begin
            check_value("br_target", target_seen, r.exp_target);
        end
        if (r.chk_mem) begin
            check_value("memory word", mem_model.mem[r.chk_addr[8:1]], r.chk_word);
        end
        // one result per row
        @(negedge clk);
        check_value("wb_item.valid", 16'(wb_item.valid), 16'd0);
    endtask

    initial begin
        void'($urandom(32'he2d9));
        cycles   = 0;
        rst_n    = 1'b0;
        in_item  = '0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/100ps
`include "lc3b_macros.svh"

module tb_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        read,
    input  logic        write,
    input  logic [1:0]  wmask,
    input  logic [15:0] address,
    input  logic [15:0] wdata,
    output logic        resp,
    output logic [15:0] rdata
);

    logic [15:0] mem [`TB_MEM_WORDS];
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [7:0]  idx;

    assign idx = address[8:1];

    // every word holds its index in the high byte and the inverted index below
    initial begin
        for (int i = 0; i < `TB_MEM_WORDS; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            resp     <= 1'b0;
            rdata    <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (resp) begin
            resp <= 1'b0;
            busy <= 1'b0;
        end else if (read || write) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= 2'($urandom % 4);
            end else if (wait_cnt == 0) begin
                resp  <= 1'b1;
                rdata <= mem[idx];
                if (write && wmask[0]) mem[idx][7:0] <= wdata[7:0];
                if (write && wmask[1]) mem[idx][15:8] <= wdata[15:8];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// File: verilog.f
+incdir+.
lc3b_types.sv
pipe_reg.sv
mem_access.sv
mem_result.sv
lc3b_mem_pipe.sv
tb_mem_model.sv
tb_lc3b_mem_pipe.sv
